/* design/mips_pkg.sv */
package mips_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0]  reg_addr_t;
	typedef logic [3:0]  strb_t;

	// one-hot control states
	typedef enum logic [8:0] {
		INIT = 9'b000000001,
		IF   = 9'b000000010,
		IW   = 9'b000000100,
		ID   = 9'b000001000,
		EX   = 9'b000010000,
		ST   = 9'b000100000,
		LD   = 9'b001000000,
		RDW  = 9'b010000000,
		WB   = 9'b100000000
	} state_t;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_NOR,
		ALU_SLT,
		ALU_SLTU,
		ALU_LUI
	} alu_op_t;

	typedef struct packed {
		alu_op_t   alu_op;
		logic      use_imm;
		logic      reg_write;
		reg_addr_t dest;
		logic      is_load;
		logic      is_store;
		logic      is_branch;
		logic      branch_ne;
		logic      is_jump;
		logic      is_nop;
	} ctrl_t;

	typedef struct packed {
		word_t pc;
		logic  valid;
	} inst_req_t;

	typedef struct packed {
		word_t addr;
		word_t wdata;
		strb_t strb;
		logic  read;
		logic  write;
	} mem_req_t;

	typedef struct packed {
		logic      valid;
		logic      wen;
		reg_addr_t waddr;
		word_t     wdata;
		word_t     pc;
	} retire_t;

	localparam word_t RESET_PC = 32'h0000_0000;

	// opcodes
	localparam logic [5:0] OP_SPECIAL = 6'h00;
	localparam logic [5:0] OP_J       = 6'h02;
	localparam logic [5:0] OP_BEQ     = 6'h04;
	localparam logic [5:0] OP_BNE     = 6'h05;
	localparam logic [5:0] OP_ADDIU   = 6'h09;
	localparam logic [5:0] OP_SLTI    = 6'h0a;
	localparam logic [5:0] OP_SLTIU   = 6'h0b;
	localparam logic [5:0] OP_ANDI    = 6'h0c;
	localparam logic [5:0] OP_ORI     = 6'h0d;
	localparam logic [5:0] OP_XORI    = 6'h0e;
	localparam logic [5:0] OP_LUI     = 6'h0f;
	localparam logic [5:0] OP_LW      = 6'h23;
	localparam logic [5:0] OP_SW      = 6'h2b;

	// SPECIAL function codes
	localparam logic [5:0] FN_ADDU = 6'h21;
	localparam logic [5:0] FN_SUBU = 6'h23;
	localparam logic [5:0] FN_AND  = 6'h24;
	localparam logic [5:0] FN_OR   = 6'h25;
	localparam logic [5:0] FN_XOR  = 6'h26;
	localparam logic [5:0] FN_NOR  = 6'h27;
	localparam logic [5:0] FN_SLT  = 6'h2a;
	localparam logic [5:0] FN_SLTU = 6'h2b;

	localparam strb_t STRB_WORD = 4'b1111;

endpackage

/* design/fetch_unit.sv */
module fetch_unit (
	input  logic                clk,
	input  logic                rst,
	input  mips_pkg::state_t    state,
	input  mips_pkg::ctrl_t     ctrl,
	input  logic                pc_advance,
	input  logic                alu_zero,
	input  mips_pkg::word_t     instruction,
	input  logic                inst_req_ready,
	input  logic                inst_valid,
	output mips_pkg::inst_req_t inst_req,
	output logic                inst_ready,
	output mips_pkg::word_t     inst_word,
	output mips_pkg::word_t     pc
);
	import mips_pkg::*;

	word_t pc_plus4;
	word_t branch_target;
	word_t jump_target;
	word_t pc_next;
	logic  taken;
	logic  req_sent;

	assign pc_plus4      = pc + 32'd4;
	assign branch_target = pc_plus4 + {{14{inst_word[15]}}, inst_word[15:0], 2'b00};
	assign jump_target   = {pc[31:28], inst_word[25:0], 2'b00};

	// beq taken on equal, bne on not equal
	assign taken   = ctrl.is_branch & (alu_zero ^ ctrl.branch_ne);
	assign pc_next = ctrl.is_jump ? jump_target : (taken ? branch_target : pc_plus4);

	assign inst_req   = '{pc: pc, valid: (state == IF)};
	assign inst_ready = (state == IW) & req_sent;

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= RESET_PC;
		end else if (pc_advance) begin
			pc <= pc_next;
		end
	end

	// remembers an accepted request until its response arrives
	always_ff @(posedge clk) begin
		if (rst) begin
			req_sent <= 1'b0;
		end else if (inst_req.valid && inst_req_ready) begin
			req_sent <= 1'b1;
		end else if (inst_valid && inst_ready) begin
			req_sent <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (inst_valid && inst_ready) begin
			inst_word <= instruction;
		end
	end

endmodule

/* design/decoder.sv */
module decoder (
	input  mips_pkg::word_t     inst_word,
	output mips_pkg::ctrl_t     ctrl,
	output mips_pkg::word_t     imm,
	output mips_pkg::reg_addr_t rs,
	output mips_pkg::reg_addr_t rt
);
	import mips_pkg::*;

	logic [5:0] opcode;
	logic [5:0] funct;
	reg_addr_t  rd;
	logic       zero_ext;
	logic       known;
	ctrl_t      c;

	assign opcode = inst_word[31:26];
	assign funct  = inst_word[5:0];
	assign rs     = inst_word[25:21];
	assign rt     = inst_word[20:16];
	assign rd     = inst_word[15:11];

	always_comb begin
		c          = '0;
		c.alu_op   = ALU_ADD;
		c.dest     = rt;
		zero_ext   = 1'b0;
		known      = 1'b1;
		case (opcode)
			OP_SPECIAL: begin
				c.dest      = rd;
				c.reg_write = 1'b1;
				case (funct)
					FN_ADDU: c.alu_op = ALU_ADD;
					FN_SUBU: c.alu_op = ALU_SUB;
					FN_AND:  c.alu_op = ALU_AND;
					FN_OR:   c.alu_op = ALU_OR;
					FN_XOR:  c.alu_op = ALU_XOR;
					FN_NOR:  c.alu_op = ALU_NOR;
					FN_SLT:  c.alu_op = ALU_SLT;
					FN_SLTU: c.alu_op = ALU_SLTU;
					default: known = 1'b0;
				endcase
			end
			OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
				c.use_imm   = 1'b1;
				c.reg_write = 1'b1;
				case (opcode)
					OP_SLTI:  c.alu_op = ALU_SLT;
					OP_SLTIU: c.alu_op = ALU_SLTU;
					OP_ANDI:  c.alu_op = ALU_AND;
					OP_ORI:   c.alu_op = ALU_OR;
					OP_XORI:  c.alu_op = ALU_XOR;
					OP_LUI:   c.alu_op = ALU_LUI;
					default:  c.alu_op = ALU_ADD;
				endcase
				// logical immediates are zero-extended
				zero_ext = (opcode == OP_ANDI) | (opcode == OP_ORI) | (opcode == OP_XORI);
			end
			OP_LW: begin
				c.use_imm   = 1'b1;
				c.reg_write = 1'b1;
				c.is_load   = 1'b1;
			end
			OP_SW: begin
				c.use_imm  = 1'b1;
				c.is_store = 1'b1;
			end
			OP_BEQ, OP_BNE: begin
				c.alu_op    = ALU_SUB;
				c.is_branch = 1'b1;
				c.branch_ne = (opcode == OP_BNE);
			end
			OP_J:    c.is_jump = 1'b1;
			default: known = 1'b0;
		endcase
		// anything unsupported, including the all-zero word, retires as a nop
		if (!known) begin
			c        = '0;
			c.is_nop = 1'b1;
		end
		if (c.dest == '0) begin
			c.reg_write = 1'b0;
		end
	end

	assign ctrl = c;
	assign imm  = zero_ext ? {16'b0, inst_word[15:0]} : {{16{inst_word[15]}}, inst_word[15:0]};

endmodule

/* design/reg_file.sv */
module reg_file (
	input  logic                clk,
	input  mips_pkg::reg_addr_t raddr1,
	input  mips_pkg::reg_addr_t raddr2,
	input  mips_pkg::reg_addr_t waddr,
	input  logic                wen,
	input  mips_pkg::word_t     wdata,
	output mips_pkg::word_t     rdata1,
	output mips_pkg::word_t     rdata2
);
	import mips_pkg::*;

	word_t regs [32];

	always_ff @(posedge clk) begin
		if (wen && waddr != '0) begin
			regs[waddr] <= wdata;
		end
	end

	// register zero is hardwired
	assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
	assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

/* design/alu.sv */
module alu (
	input  mips_pkg::alu_op_t op,
	input  mips_pkg::word_t   a,
	input  mips_pkg::word_t   b,
	output mips_pkg::word_t   result,
	output logic              zero
);
	import mips_pkg::*;

	logic slt_signed;
	logic slt_unsigned;

	assign slt_signed   = $signed(a) < $signed(b);
	assign slt_unsigned = a < b;

	always_comb begin
		case (op)
			ALU_ADD:  result = a + b;
			ALU_SUB:  result = a - b;
			ALU_AND:  result = a & b;
			ALU_OR:   result = a | b;
			ALU_XOR:  result = a ^ b;
			ALU_NOR:  result = ~(a | b);
			ALU_SLT:  result = {31'b0, slt_signed};
			ALU_SLTU: result = {31'b0, slt_unsigned};
			// low half of b into the upper half
			ALU_LUI:  result = {b[15:0], 16'b0};
			default:  result = '0;
		endcase
	end

	// branches compare through ALU_SUB
	assign zero = (result == '0);

endmodule

/* design/core_control.sv */
module core_control (
	input  logic              clk,
	input  logic              rst,
	input  mips_pkg::ctrl_t   ctrl,
	input  logic              inst_req_ready,
	input  logic              inst_valid,
	input  logic              mem_req_ready,
	input  logic              read_data_valid,
	input  mips_pkg::word_t   alu_result,
	input  mips_pkg::word_t   load_word,
	input  mips_pkg::word_t   pc,
	output mips_pkg::state_t  state,
	output logic              pc_advance,
	output logic              rf_wen,
	output mips_pkg::word_t   rf_wdata,
	output mips_pkg::retire_t retire,
	output mips_pkg::word_t   cycle_count,
	output mips_pkg::word_t   retired_count
);
	import mips_pkg::*;

	state_t    state_next;
	logic      retire_fire;
	reg_addr_t ret_waddr;
	word_t     ret_wdata;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= INIT;
		end else begin
			state <= state_next;
		end
	end

	// handshakes stall the FSM in place
	always_comb begin
		state_next = state;
		case (state)
			INIT: state_next = IF;
			IF:   if (inst_req_ready) state_next = IW;
			IW:   if (inst_valid) state_next = ID;
			ID:   state_next = ctrl.is_nop ? IF : EX;
			EX: begin
				if (ctrl.is_branch || ctrl.is_jump) begin
					state_next = IF;
				end else if (ctrl.is_store) begin
					state_next = ST;
				end else if (ctrl.is_load) begin
					state_next = LD;
				end else begin
					state_next = WB;
				end
			end
			ST:      if (mem_req_ready) state_next = IF;
			LD:      if (mem_req_ready) state_next = RDW;
			RDW:     if (read_data_valid) state_next = WB;
			WB:      state_next = IF;
			default: state_next = INIT;
		endcase
	end

	// last cycle of each instruction
	assign retire_fire = (state == WB)
		| ((state == ST) & mem_req_ready)
		| ((state == EX) & (ctrl.is_branch | ctrl.is_jump))
		| ((state == ID) & ctrl.is_nop);

	assign pc_advance = retire_fire;
	assign rf_wen     = (state == WB) & ctrl.reg_write;
	assign rf_wdata   = ctrl.is_load ? load_word : alu_result;

	assign ret_waddr = rf_wen ? ctrl.dest : '0;
	assign ret_wdata = rf_wen ? rf_wdata : '0;
	assign retire    = '{valid: retire_fire, wen: rf_wen, waddr: ret_waddr,
		wdata: ret_wdata, pc: pc};

	always_ff @(posedge clk) begin
		if (rst) begin
			cycle_count <= '0;
		end else begin
			cycle_count <= cycle_count + 32'd1;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			retired_count <= '0;
		end else if (retire_fire) begin
			retired_count <= retired_count + 32'd1;
		end
	end

endmodule

/* design/mem_access.sv */
module mem_access (
	input  logic               clk,
	input  mips_pkg::state_t   state,
	input  mips_pkg::ctrl_t    ctrl,
	input  mips_pkg::word_t    alu_result,
	input  mips_pkg::word_t    store_data,
	output mips_pkg::mem_req_t mem_req,
	input  mips_pkg::word_t    read_data,
	output logic               read_data_ready,
	output mips_pkg::word_t    load_word
);
	import mips_pkg::*;

	logic  do_write;
	logic  do_read;
	strb_t strb;
	word_t addr;

	assign do_write = (state == ST) & ctrl.is_store;
	assign do_read  = (state == LD) & ctrl.is_load;
	assign strb     = do_write ? STRB_WORD : '0;

	// word accesses only
	assign addr = {alu_result[31:2], 2'b00};

	assign mem_req = '{addr: addr, wdata: store_data, strb: strb,
		read: do_read, write: do_write};

	assign read_data_ready = (state == RDW);

	always_ff @(posedge clk) begin
		if (read_data_ready) begin
			load_word <= read_data;
		end
	end

endmodule

/* design/mips_core.sv */
module mips_core (
	input  logic                clk,
	input  logic                rst,
	output mips_pkg::inst_req_t inst_req,
	input  logic                inst_req_ready,
	input  mips_pkg::word_t     instruction,
	input  logic                inst_valid,
	output logic                inst_ready,
	output mips_pkg::mem_req_t  mem_req,
	input  logic                mem_req_ready,
	input  mips_pkg::word_t     read_data,
	input  logic                read_data_valid,
	output logic                read_data_ready,
	output mips_pkg::retire_t   retire,
	output mips_pkg::word_t     cycle_count,
	output mips_pkg::word_t     retired_count
);
	import mips_pkg::*;

	state_t    state;
	ctrl_t     ctrl;
	word_t     imm;
	word_t     inst_word;
	word_t     pc;
	reg_addr_t rs;
	reg_addr_t rt;
	word_t     rs_data;
	word_t     rt_data;
	word_t     alu_b;
	word_t     alu_result;
	logic      alu_zero;
	word_t     load_word;
	logic      pc_advance;
	logic      rf_wen;
	word_t     rf_wdata;

	// operand b is the immediate for I-type and memory instructions
	assign alu_b = ctrl.use_imm ? imm : rt_data;

	fetch_unit fetch_unit_inst (
		.clk            (clk),
		.rst            (rst),
		.state          (state),
		.ctrl           (ctrl),
		.pc_advance     (pc_advance),
		.alu_zero       (alu_zero),
		.instruction    (instruction),
		.inst_req_ready (inst_req_ready),
		.inst_valid     (inst_valid),
		.inst_req       (inst_req),
		.inst_ready     (inst_ready),
		.inst_word      (inst_word),
		.pc             (pc)
	);

	decoder decoder_inst (
		.inst_word (inst_word),
		.ctrl      (ctrl),
		.imm       (imm),
		.rs        (rs),
		.rt        (rt)
	);

	reg_file reg_file_inst (
		.clk    (clk),
		.raddr1 (rs),
		.raddr2 (rt),
		.waddr  (ctrl.dest),
		.wen    (rf_wen),
		.wdata  (rf_wdata),
		.rdata1 (rs_data),
		.rdata2 (rt_data)
	);

	alu alu_inst (
		.op     (ctrl.alu_op),
		.a      (rs_data),
		.b      (alu_b),
		.result (alu_result),
		.zero   (alu_zero)
	);

	core_control core_control_inst (
		.clk             (clk),
		.rst             (rst),
		.ctrl            (ctrl),
		.inst_req_ready  (inst_req_ready),
		.inst_valid      (inst_valid),
		.mem_req_ready   (mem_req_ready),
		.read_data_valid (read_data_valid),
		.alu_result      (alu_result),
		.load_word       (load_word),
		.pc              (pc),
		.state           (state),
		.pc_advance      (pc_advance),
		.rf_wen          (rf_wen),
		.rf_wdata        (rf_wdata),
		.retire          (retire),
		.cycle_count     (cycle_count),
		.retired_count   (retired_count)
	);

	mem_access mem_access_inst (
		.clk             (clk),
		.state           (state),
		.ctrl            (ctrl),
		.alu_result      (alu_result),
		.store_data      (rt_data),
		.mem_req         (mem_req),
		.read_data       (read_data),
		.read_data_ready (read_data_ready),
		.load_word       (load_word)
	);

endmodule

/* verif/mips_core_assertions.sv */
module mips_core_assertions (
	input logic                clk,
	input logic                rst,
	input mips_pkg::state_t    state,
	input logic                inst_req_ready,
	input logic                mem_req_ready,
	input mips_pkg::word_t     alu_result,
	input mips_pkg::word_t     pc,
	input mips_pkg::retire_t   retire
);
	import mips_pkg::*;

	int failures = 0;

	// fetch request keeps its pc until accepted
	assert property (@(posedge clk) disable iff (rst)
		(state == IF && !inst_req_ready) |=> (state == IF && $stable(pc)))
	else begin
		failures++;
		$error("instruction request changed before it was accepted");
	end

	// load and store requests hold state and address
	assert property (@(posedge clk) disable iff (rst)
		((state == ST || state == LD) && !mem_req_ready)
		|=> (state == $past(state) && $stable(alu_result)))
	else begin
		failures++;
		$error("memory request changed before it was accepted");
	end

	assert property (@(posedge clk) disable iff (rst)
		retire.valid |=> !retire.valid)
	else begin
		failures++;
		$error("retire valid held for more than one cycle");
	end

	assert property (@(posedge clk) disable iff (rst)
		!retire.wen |-> (retire.wdata == '0 && retire.waddr == '0))
	else begin
		failures++;
		$error("retire record carries write data without a write");
	end

endmodule

bind core_control mips_core_assertions assertions_inst (
	.clk            (clk),
	.rst            (rst),
	.state          (state),
	.inst_req_ready (inst_req_ready),
	.mem_req_ready  (mem_req_ready),
	.alu_result     (alu_result),
	.pc             (pc),
	.retire         (retire)
);

/* verif/mips_core_tb.sv */
module mips_core_tb;
	import mips_pkg::*;

	localparam int ALU_PROG = 0;
	localparam int MEM_PROG = 1;
	localparam int BR_PROG  = 2;
	localparam int NOP_PROG = 3;

	// retirements per program, branch program counts its loop
	localparam int ALU_LEN = 18;
	localparam int MEM_LEN = 8;
	localparam int BR_LEN  = 15;
	localparam int NOP_LEN = 5;
	localparam int RUNS    = 8;
	localparam int TIMEOUT_CYCLES =
		40 * (ALU_LEN + 3 * MEM_LEN + 3 * BR_LEN + NOP_LEN) + 10 * RUNS + 40;

	logic      clk;
	logic      rst;
	inst_req_t inst_req;
	logic      inst_req_ready;
	word_t     instruction;
	logic      inst_valid;
	logic      inst_ready;
	mem_req_t  mem_req;
	logic      mem_req_ready;
	word_t     read_data;
	logic      read_data_valid;
	logic      read_data_ready;
	retire_t   retire;
	word_t     cycle_count;
	word_t     retired_count;

	word_t     imem [256];
	word_t     dmem [256];
	word_t     mdm [256];
	retire_t   ret_q [$];
	retire_t   exp_q [$];
	int        prog_len;
	int        retire_seen = 0;
	int        clock_cycles = 0;
	int        release_cycle = 0;
	int        errors = 0;
	int        checks = 0;
	int        tests = 0;
	logic      waits_on = 1'b0;
	logic [31:0] rng_state = 32'h59963f1e;

	logic      fetch_pending = 1'b0;
	word_t     fetch_pc;
	int        fetch_req_wait = 0;
	int        fetch_resp_wait = 0;
	logic      load_pending = 1'b0;
	word_t     load_addr;
	int        mem_wait = 0;
	int        load_wait = 0;

	mips_core mips_core_inst (
		.clk             (clk),
		.rst             (rst),
		.inst_req        (inst_req),
		.inst_req_ready  (inst_req_ready),
		.instruction     (instruction),
		.inst_valid      (inst_valid),
		.inst_ready      (inst_ready),
		.mem_req         (mem_req),
		.mem_req_ready   (mem_req_ready),
		.read_data       (read_data),
		.read_data_valid (read_data_valid),
		.read_data_ready (read_data_ready),
		.retire          (retire),
		.cycle_count     (cycle_count),
		.retired_count   (retired_count)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// 0 to 3 wait cycles
	function automatic int pick_wait();
		if (!waits_on) begin
			return 0;
		end
		rng_state = xorshift(rng_state);
		return int'(rng_state[1:0]);
	endfunction

	function automatic word_t r_type(input logic [5:0] fn, input reg_addr_t rd,
		input reg_addr_t rs, input reg_addr_t rt);
		return {OP_SPECIAL, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic word_t i_type(input logic [5:0] op, input reg_addr_t rt,
		input reg_addr_t rs, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic word_t j_type(input logic [25:0] target);
		return {OP_J, target};
	endfunction

	task automatic check_value(input string name, input word_t got, input word_t exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("[FAIL] t=%0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	// instruction memory: request ready, then response after a wait
	always begin
		@(posedge clk);
		if (rst) begin
			fetch_pending = 1'b0;
			fetch_req_wait = 0;
		end else if (inst_req.valid && inst_req_ready) begin
			fetch_pending = 1'b1;
			fetch_pc = inst_req.pc;
			fetch_resp_wait = pick_wait();
			fetch_req_wait = pick_wait();
		end else if (inst_valid && inst_ready) begin
			fetch_pending = 1'b0;
		end
		#1;
		inst_req_ready = 1'b0;
		if (!rst && inst_req.valid) begin
			if (fetch_req_wait == 0) begin
				inst_req_ready = 1'b1;
			end else begin
				fetch_req_wait--;
			end
		end
		inst_valid = 1'b0;
		if (fetch_pending) begin
			if (fetch_resp_wait == 0) begin
				inst_valid = 1'b1;
				instruction = imem[fetch_pc[9:2]];
			end else begin
				fetch_resp_wait--;
			end
		end
	end

	// data memory
	always begin
		@(posedge clk);
		if (rst) begin
			load_pending = 1'b0;
			mem_wait = 0;
		end else if ((mem_req.read || mem_req.write) && mem_req_ready) begin
			if (mem_req.write) begin
				check_value("mem_req.strb", mem_req.strb, 32'hf);
				dmem[mem_req.addr[9:2]] = mem_req.wdata;
			end else begin
				load_pending = 1'b1;
				load_addr = mem_req.addr;
				load_wait = pick_wait();
			end
			mem_wait = pick_wait();
		end else if (read_data_valid && read_data_ready) begin
			load_pending = 1'b0;
		end
		#1;
		mem_req_ready = 1'b0;
		if (!rst && (mem_req.read || mem_req.write)) begin
			if (mem_wait == 0) begin
				mem_req_ready = 1'b1;
			end else begin
				mem_wait--;
			end
		end
		read_data_valid = 1'b0;
		if (load_pending) begin
			if (load_wait == 0) begin
				read_data_valid = 1'b1;
				read_data = dmem[load_addr[9:2]];
			end else begin
				load_wait--;
			end
		end
	end

	always @(posedge clk) begin
		if (!rst && retire.valid === 1'b1) begin
			ret_q.push_back(retire);
			retire_seen++;
		end
	end

	always @(posedge clk) begin
		clock_cycles++;
		if (clock_cycles > TIMEOUT_CYCLES) begin
			$display("timeout after %0d cycles, the core stopped retiring", clock_cycles);
			$display("** FAIL **");
			$finish;
		end
	end

	task automatic emit(input word_t w);
		imem[prog_len] = w;
		prog_len++;
	endtask

	task automatic load_program(input int which, output int n);
		foreach (imem[i]) imem[i] = '0;
		foreach (dmem[i]) dmem[i] = 32'h5a5a_0000 ^ (i << 2);
		prog_len = 0;
		case (which)
			ALU_PROG: begin
				emit(i_type(OP_ADDIU, 1, 0, 16'h1234));
				emit(i_type(OP_LUI, 2, 0, 16'hf0f0));
				emit(i_type(OP_ORI, 2, 2, 16'h00ff));
				emit(i_type(OP_ADDIU, 3, 0, 16'hfffb));
				emit(r_type(FN_ADDU, 4, 1, 2));
				emit(r_type(FN_SUBU, 5, 1, 2));
				emit(r_type(FN_AND, 6, 1, 2));
				emit(r_type(FN_OR, 7, 1, 3));
				emit(r_type(FN_XOR, 8, 2, 3));
				emit(r_type(FN_NOR, 9, 1, 2));
				emit(r_type(FN_SLT, 10, 3, 1));
				emit(r_type(FN_SLTU, 11, 3, 1));
				emit(i_type(OP_ANDI, 12, 3, 16'hff00));
				emit(i_type(OP_XORI, 13, 2, 16'hffff));
				emit(i_type(OP_SLTI, 14, 1, 16'hffff));
				emit(i_type(OP_SLTIU, 15, 1, 16'hffff));
				// destination r0
				emit(r_type(FN_ADDU, 0, 1, 2));
				emit(i_type(OP_ADDIU, 0, 1, 16'h0007));
				n = ALU_LEN;
			end
			MEM_PROG: begin
				emit(i_type(OP_ADDIU, 1, 0, 16'h0040));
				emit(i_type(OP_LUI, 2, 0, 16'hcafe));
				emit(i_type(OP_ORI, 2, 2, 16'hbeef));
				emit(i_type(OP_SW, 2, 1, 16'h0004));
				emit(i_type(OP_LW, 3, 1, 16'h0004));
				emit(i_type(OP_SW, 3, 1, 16'hfff8));
				emit(i_type(OP_LW, 5, 1, 16'hfff8));
				emit(i_type(OP_LW, 6, 0, 16'h0080));
				n = MEM_LEN;
			end
			BR_PROG: begin
				emit(i_type(OP_ADDIU, 1, 0, 16'h0003));
				emit(i_type(OP_ADDIU, 2, 0, 16'h0003));
				emit(i_type(OP_BEQ, 2, 1, 16'h0002));
				emit(i_type(OP_ADDIU, 3, 0, 16'h0001));
				emit(i_type(OP_ADDIU, 3, 0, 16'h0002));
				emit(i_type(OP_BNE, 2, 1, 16'h0003));
				emit(i_type(OP_ADDIU, 4, 0, 16'h0009));
				emit(i_type(OP_BNE, 4, 1, 16'h0001));
				emit(i_type(OP_ADDIU, 5, 0, 16'h0001));
				emit(i_type(OP_BEQ, 4, 1, 16'h0005));
				emit(j_type(26'd12));
				emit(i_type(OP_ADDIU, 6, 0, 16'h0001));
				emit(i_type(OP_ADDIU, 7, 0, 16'h0007));
				emit(i_type(OP_ADDIU, 9, 0, 16'h0002));
				// two-pass countdown loop
				emit(i_type(OP_ADDIU, 9, 9, 16'hffff));
				emit(i_type(OP_BNE, 0, 9, 16'hfffe));
				emit(i_type(OP_ADDIU, 10, 0, 16'h0001));
				n = BR_LEN;
			end
			default: begin
				emit(i_type(OP_ADDIU, 1, 0, 16'h0001));
				emit(32'h0000_0000);
				emit(32'h0000_0000);
				emit(32'hfc00_0000);
				emit(i_type(OP_ADDIU, 2, 1, 16'h0001));
				n = NOP_LEN;
			end
		endcase
	endtask

	// instruction-level model of the kept MIPS subset
	task automatic model_program(input int n);
		word_t      regs [32];
		word_t      pc;
		word_t      inst;
		word_t      a;
		word_t      b;
		word_t      sext;
		word_t      zext;
		word_t      addr;
		word_t      res;
		word_t      next_pc;
		reg_addr_t  dst;
		logic       wen;
		exp_q.delete();
		mdm = dmem;
		foreach (regs[i]) regs[i] = '0;
		pc = RESET_PC;
		repeat (n) begin
			inst = imem[pc[9:2]];
			a = regs[inst[25:21]];
			b = regs[inst[20:16]];
			sext = {{16{inst[15]}}, inst[15:0]};
			zext = {16'h0, inst[15:0]};
			addr = a + sext;
			next_pc = pc + 32'd4;
			dst = inst[20:16];
			wen = 1'b1;
			res = '0;
			case (inst[31:26])
				OP_SPECIAL: begin
					dst = inst[15:11];
					case (inst[5:0])
						FN_ADDU: res = a + b;
						FN_SUBU: res = a - b;
						FN_AND:  res = a & b;
						FN_OR:   res = a | b;
						FN_XOR:  res = a ^ b;
						FN_NOR:  res = ~(a | b);
						FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
						FN_SLTU: res = (a < b) ? 32'd1 : 32'd0;
						default: wen = 1'b0;
					endcase
				end
				OP_ADDIU: res = a + sext;
				OP_SLTI:  res = ($signed(a) < $signed(sext)) ? 32'd1 : 32'd0;
				OP_SLTIU: res = (a < sext) ? 32'd1 : 32'd0;
				OP_ANDI:  res = a & zext;
				OP_ORI:   res = a | zext;
				OP_XORI:  res = a ^ zext;
				OP_LUI:   res = {inst[15:0], 16'h0};
				OP_LW:    res = mdm[addr[9:2]];
				OP_SW: begin
					wen = 1'b0;
					mdm[addr[9:2]] = b;
				end
				OP_BEQ: begin
					wen = 1'b0;
					if (a == b) next_pc = next_pc + {sext[29:0], 2'b00};
				end
				OP_BNE: begin
					wen = 1'b0;
					if (a != b) next_pc = next_pc + {sext[29:0], 2'b00};
				end
				OP_J: begin
					wen = 1'b0;
					next_pc = {next_pc[31:28], inst[25:0], 2'b00};
				end
				default: wen = 1'b0;
			endcase
			if (dst == '0) wen = 1'b0;
			if (wen) regs[dst] = res;
			exp_q.push_back('{valid: 1'b1, wen: wen, waddr: wen ? dst : 5'd0,
				wdata: wen ? res : 32'd0, pc: pc});
			pc = next_pc;
		end
	endtask

	task automatic reset_dut();
		@(posedge clk);
		#1;
		rst = 1'b1;
		repeat (5) @(posedge clk);
		#1;
		rst = 1'b0;
		release_cycle = clock_cycles;
		ret_q.delete();
		retire_seen = 0;
	endtask

	task automatic run_program(input int n, input logic waits);
		waits_on = waits;
		reset_dut();
		wait (retire_seen >= n);
		@(posedge clk);
		#1;
	endtask

	task automatic compare_retires(input int n);
		for (int i = 0; i < n; i++) begin
			check_value($sformatf("retire[%0d].pc", i), ret_q[i].pc, exp_q[i].pc);
			check_value($sformatf("retire[%0d].wen", i), ret_q[i].wen, exp_q[i].wen);
			check_value($sformatf("retire[%0d].waddr", i), ret_q[i].waddr, exp_q[i].waddr);
			check_value($sformatf("retire[%0d].wdata", i), ret_q[i].wdata, exp_q[i].wdata);
		end
	endtask

	task automatic run_and_check(input int which, input logic waits, output int n);
		load_program(which, n);
		model_program(n);
		run_program(n, waits);
		compare_retires(n);
		for (int i = 0; i < 256; i++) begin
			check_value($sformatf("dmem[%0d]", i), dmem[i], mdm[i]);
		end
	endtask

	task automatic report_test(input string name, input int start_errors);
		tests++;
		if (errors == start_errors) begin
			$display("%s: ok", name);
		end else begin
			$display("%s: %0d errors", name, errors - start_errors);
		end
	endtask

	task automatic alu_test();
		int n;
		int start_errors;
		start_errors = errors;
		run_and_check(ALU_PROG, 1'b1, n);
		report_test("alu_ops", start_errors);
	endtask

	task automatic store_load_test();
		int n;
		int start_errors;
		start_errors = errors;
		run_and_check(MEM_PROG, 1'b1, n);
		// word stored at 0x44 comes back on the load
		check_value("dmem[0x44]", dmem[17], 32'hcafe_beef);
		check_value("lw wdata", ret_q[4].wdata, 32'hcafe_beef);
		report_test("store_load", start_errors);
	endtask

	task automatic branch_test();
		int n;
		int start_errors;
		start_errors = errors;
		run_and_check(BR_PROG, 1'b1, n);
		check_value("beq target pc", ret_q[3].pc, 32'h14);
		check_value("j target pc", ret_q[8].pc, 32'h30);
		check_value("loop back pc", ret_q[12].pc, 32'h38);
		report_test("branches", start_errors);
	endtask

	task automatic backpressure_test();
		retire_t ref_q [$];
		int      n;
		int      start_errors;
		start_errors = errors;
		for (int prog = MEM_PROG; prog <= BR_PROG; prog++) begin
			run_and_check(prog, 1'b0, n);
			ref_q = ret_q;
			run_and_check(prog, 1'b1, n);
			for (int i = 0; i < n; i++) begin
				check_value($sformatf("stalled retire[%0d].pc", i), ret_q[i].pc, ref_q[i].pc);
				check_value($sformatf("stalled retire[%0d].waddr", i), ret_q[i].waddr,
					ref_q[i].waddr);
				check_value($sformatf("stalled retire[%0d].wdata", i), ret_q[i].wdata,
					ref_q[i].wdata);
			end
		end
		report_test("backpressure", start_errors);
	endtask

	task automatic nop_counter_test();
		int n;
		int start_errors;
		start_errors = errors;
		run_and_check(NOP_PROG, 1'b1, n);
		check_value("nop wen", ret_q[1].wen, 0);
		check_value("nop wen", ret_q[2].wen, 0);
		check_value("unsupported wen", ret_q[3].wen, 0);
		// counters sampled twice, a few clocks apart
		repeat (2) begin
			check_value("retired_count", retired_count, retire_seen);
			check_value("cycle_count", cycle_count, clock_cycles - release_cycle);
			repeat (7) @(posedge clk);
			#1;
		end
		report_test("nop_counters", start_errors);
	endtask

	initial begin
		int total_errors;
		rst = 1'b1;
		inst_req_ready = 1'b0;
		instruction = '0;
		inst_valid = 1'b0;
		mem_req_ready = 1'b0;
		read_data = '0;
		read_data_valid = 1'b0;
		alu_test();
		store_load_test();
		branch_test();
		backpressure_test();
		nop_counter_test();
		total_errors = errors + mips_core_inst.core_control_inst.assertions_inst.failures;
		$display("tests %0d, checks %0d, errors %0d", tests, checks, total_errors);
		if (total_errors == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

/* mips_core.f */
design/mips_pkg.sv
design/fetch_unit.sv
design/decoder.sv
design/reg_file.sv
design/alu.sv
design/core_control.sv
design/mem_access.sv
design/mips_core.sv
verif/mips_core_assertions.sv
verif/mips_core_tb.sv
